// File: bench/mvu_cases.txt
// Lane array jobs, all values hex. First word: batch count. Batch: job count, then jobs
// Job: lane base stride length(count-1) mode(0 int8, 1 bin) msbidx clr_at fill weight nwords
// Then nwords "addr data" pairs, then expected acc and qout
// fill 1 loads the bank with $random words (seed 8c85) before the listed words
// clr_at gives how many leading products shacc_clr throws away, 0 for none
// Jobs of one batch start together, in rising count with a gap of at least 3
8
// Int8, plain run from address 0
1
0 00 1 3 0 07 0 1 01020304 4
00 01010101  01 02020202  02 FFFFFFFF  03 00000005
00000028 28
// Int8, stride 3 from 3E, wraps to 01
1
1 3E 3 3 0 0B 0 1 7F80017F 4
3E 7F7F7F7F  01 80808080  04 00FF0102  07 10000000
000008F0 8F
// Binary, stride 2
1
2 0A 2 2 1 07 0 1 FFFF0000 3
0A FFFF0000  0C 0000FFFF  0E FFFF000F
00000018 18
// Binary, stride 0 reads one word five times
1
3 20 0 4 1 08 0 1 00000000 1
20 00000001
00000096 4B
// Negative sum, quantizer at bit 15
1
0 05 1 1 0 0F 0 1 00000064 2
05 0000009C  06 000000C0
FFFFBFF0 BF
// Single word, quantizer at bit 16
1
1 28 1 0 0 10 0 1 7F7F7F7F 1
28 7F7F7F7F
0000FC04 7E
// Three lanes started together
3
2 00 1 0 0 1F 0 1 7F7F7F7F 1
00 81818181
FFFF03FC FF
0 3C 1 3 1 07 0 1 AAAAAAAA 4
3C AAAAAAAA  3D 55555555  3E AAAAAAAB  3F AAAAAAAA
0000003E 3E
1 03 5 7 0 07 0 1 00000001 8
03 AABBCC01  08 AABBCC02  0D 7F000003  12 80000004
17 00FF0005  1C 12345606  21 FFFFFF07  26 00000008
00000024 24
// Accumulator clear drops the first two products
1
3 00 1 5 0 07 2 1 00000001 6
00 0000000A  01 00000014  02 0000001E  03 00000028  04 00000032  05 0000003C
000000B4 B4

// File: bench/tb_mvu_array.sv
`timescale 1ns/1ps
/*
 * Testbench for the lane array. Jobs, bank words and expected results come
 * from bench/mvu_cases.txt, which a small model checks before the run.
 */
module tb_mvu_array
    import mvu_cfg_pkg::*;
    import mvu_data_pkg::*;
();

    localparam int MAXJ  = 32;                      // Jobs and batches held
    localparam int NWORD = 512;                     // Case file image size

    logic            clk;
    logic            rst_n;
    logic            cfg_wr;
    mvu_idx_t        cfg_lane;
    job_cfg_t        cfg_data;
    logic [NMVU-1:0] start;
    bank_wr_t        bank_wr;
    mvu_idx_t        wr_lane;
    logic [NMVU-1:0] shacc_clr;
    logic            ic_clr;
    mvu_idx_t        ic_recv_from;
    logic [NMVU-1:0] done;
    logic [NMVU-1:0] irq;
    lane_result_t    ic_word;
    logic            ic_valid;

    logic [31:0]  cases [NWORD];                    // Raw case file
    int           seed;
    int           cycle;
    int           limit;                            // Timeout in cycles
    int           nbatch;
    int           njob;
    int           batch_first [MAXJ];
    int           batch_jobs  [MAXJ];
    mvu_idx_t     job_lane    [MAXJ];
    job_cfg_t     job_cfg     [MAXJ];
    int           job_clr     [MAXJ];               // Leading products dropped
    int           job_fill    [MAXJ];
    int           job_nw      [MAXJ];
    int           job_words   [MAXJ];               // First address/data pair
    lane_result_t job_exp     [MAXJ];

    mvu_array_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg_lane     (cfg_lane),
        .cfg_data     (cfg_data),
        .start        (start),
        .bank_wr      (bank_wr),
        .wr_lane      (wr_lane),
        .shacc_clr    (shacc_clr),
        .ic_clr       (ic_clr),
        .ic_recv_from (ic_recv_from),
        .done         (done),
        .irq          (irq),
        .ic_word      (ic_word),
        .ic_valid     (ic_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > limit) abort_run($sformatf("Timeout, run took over %0d cycles", limit));
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input string name, input lane_result_t got,
                                input lane_result_t exp);
        if (got !== exp) abort_run($sformatf("MISMATCH %s qout %h acc %h, expected qout %h acc %h",
                                             name, got.qout, got.acc, exp.qout, exp.acc));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    function automatic int job_len(input int j);
        return int'(job_cfg[j].length) + 1;         // Stored as count minus one
    endfunction

    // Model of the two multiply modes
    function automatic int int8_dot(input logic [31:0] d, input logic [31:0] w);
        int  s;
        byte a;
        byte b;
        s = 0;
        for (int i = 0; i < 4; i++) begin
            a = d[8*i +: 8];
            b = w[8*i +: 8];
            s = s + int'(a) * int'(b);
        end
        return s;
    endfunction

    function automatic int bin_dot(input logic [31:0] d, input logic [31:0] w);
        int m;
        m = 0;
        for (int i = 0; i < 32; i++) begin
            if (d[i] == w[i]) m++;                  // Equal bits count +1
        end
        return 2 * m - 32;
    endfunction

    task automatic parse_cases();
        int p;
        p      = 1;
        nbatch = cases[0];
        njob   = 0;
        limit  = 40;                                // Reset and idle time
        for (int b = 0; b < nbatch; b++) begin
            batch_first[b] = njob;
            batch_jobs[b]  = cases[p];
            p++;
            for (int j = 0; j < batch_jobs[b]; j++) begin
                job_lane[njob]         = mvu_idx_t'(cases[p]);
                job_cfg[njob].base     = cases[p+1][BDBANKA-1:0];
                job_cfg[njob].stride   = cases[p+2][BSTRIDE-1:0];
                job_cfg[njob].length   = cases[p+3][BLENGTH-1:0];
                job_cfg[njob].mode     = mul_mode_e'(cases[p+4][1:0]);
                job_cfg[njob].msbidx   = cases[p+5][BQMSBIDX-1:0];
                job_clr[njob]          = cases[p+6];
                job_fill[njob]         = cases[p+7];
                job_cfg[njob].weight   = cases[p+8];
                job_nw[njob]           = cases[p+9];
                job_words[njob]        = p + 10;
                p                      = p + 10 + 2 * job_nw[njob];
                job_exp[njob].acc      = cases[p];
                job_exp[njob].qout     = cases[p+1][BQOUT-1:0];
                p                      = p + 2;
                // Run plus loading plus setup
                limit += job_len(njob) + 10 + job_nw[njob] + 64 * job_fill[njob] + 8;
                njob++;
            end
        end
    endtask

    task automatic read_word(input int j, input int a, output logic [31:0] d);
        int found;
        found = 0;
        d     = '0;
        for (int k = 0; k < job_nw[j]; k++) begin
            if (int'(cases[job_words[j] + 2*k]) == a) begin
                d     = cases[job_words[j] + 2*k + 1];
                found = 1;
            end
        end
        if (found == 0) abort_run($sformatf("Case file job %0d reads address %0h it never loads", j, a));
    endtask

    // Recomputes every expected result from the job fields and bank words
    task automatic check_case_file();
        int           acc;
        int           a;
        int           p;
        logic [31:0]  d;
        lane_result_t m;
        for (int j = 0; j < njob; j++) begin
            if (job_cfg[j].msbidx < 7) abort_run($sformatf("Case file job %0d has msbidx below 7", j));
            acc = 0;
            for (int i = 0; i < job_len(j); i++) begin
                a = (int'(job_cfg[j].base) + i * int'(job_cfg[j].stride)) % 64;  // Wraps at 64
                read_word(j, a, d);
                if (job_cfg[j].mode == MUL_INT8) p = int8_dot(d, job_cfg[j].weight);
                else p = bin_dot(d, job_cfg[j].weight);
                if (i >= job_clr[j]) acc = acc + p;
            end
            m.acc  = acc;
            m.qout = 8'(acc >>> (int'(job_cfg[j].msbidx) - 7));
            if (m !== job_exp[j]) abort_run($sformatf("Case file job %0d expects %h, the rules give %h",
                                                      j, job_exp[j], m));
        end
        for (int b = 0; b < nbatch; b++) begin
            for (int j = batch_first[b] + 1; j < batch_first[b] + batch_jobs[b]; j++) begin
                if (job_len(j) < job_len(j - 1) + 3)
                    abort_run($sformatf("Case file batch %0d ends its jobs too close together", b));
            end
        end
    endtask

    task automatic load_bank(input int j);
        bank_wr_t w;
        w    = '0;
        w.en = 1'b1;
        if (job_fill[j] != 0) begin
            for (int a = 0; a < 64; a++) begin
                @(posedge clk);
                w.addr      = bank_addr_t'(a);
                w.data.bits = $random(seed);        // Garbage for a wrong address to hit
                bank_wr <= w;
                wr_lane <= job_lane[j];
            end
        end
        for (int k = 0; k < job_nw[j]; k++) begin
            @(posedge clk);
            w.addr      = cases[job_words[j] + 2*k][BDBANKA-1:0];
            w.data.bits = cases[job_words[j] + 2*k + 1];
            bank_wr <= w;
            wr_lane <= job_lane[j];
        end
        @(posedge clk);
        bank_wr <= '0;
    endtask

    task automatic write_cfg(input int j);
        @(posedge clk);
        cfg_wr   <= 1'b1;
        cfg_lane <= job_lane[j];
        cfg_data <= job_cfg[j];
        @(posedge clk);
        cfg_wr   <= 1'b0;
    endtask

    // Starts a batch together, then reads each lane in turn and clears the readout
    task automatic run_batch(input int b);
        int              f;
        int              k;
        int              jr;
        int              phase;                     // 0 wait, 1 clear sent, 2 clear seen
        logic [NMVU-1:0] sv;
        logic [NMVU-1:0] cv;
        f  = batch_first[b];
        sv = '0;
        for (int j = f; j < f + batch_jobs[b]; j++) begin
            load_bank(j);
            write_cfg(j);
            sv[job_lane[j]] = 1'b1;
        end
        @(posedge clk);
        ic_recv_from <= job_lane[f];
        @(posedge clk);
        start <= sv;
        k     = 0;
        jr    = f;
        phase = 0;
        while (jr < f + batch_jobs[b]) begin
            @(negedge clk);
            for (int j = f; j < f + batch_jobs[b] && k > 0; j++) begin
                check_flag($sformatf("irq[%0d]", job_lane[j]), irq[job_lane[j]], k == job_len(j) + 2);
                check_flag($sformatf("done[%0d]", job_lane[j]), done[job_lane[j]], k >= job_len(j) + 2);
            end
            if (phase == 0) begin
                check_flag("ic_valid", ic_valid, k == job_len(jr) + 3);  // Exactly L+3 after start
                if (k == job_len(jr) + 3) begin
                    check_result("ic_word", ic_word, job_exp[jr]);
                    phase = 1;
                end
            end else if (phase == 1) begin
                check_flag("ic_valid", ic_valid, 1'b1);  // Clear not sampled yet
                phase = 2;
            end else begin
                check_flag("ic_valid", ic_valid, 1'b0);
                jr++;
                phase = 0;
            end
            @(posedge clk);
            k++;
            cv = '0;
            for (int j = f; j < f + batch_jobs[b]; j++) begin
                if (job_clr[j] != 0 && k == job_clr[j] + 1) cv[job_lane[j]] = 1'b1;
            end
            if (k == 1) start <= '0;
            shacc_clr <= cv;
            ic_clr    <= (phase == 1);
            if (phase == 1 && jr + 1 < f + batch_jobs[b]) ic_recv_from <= job_lane[jr + 1];
        end
    endtask

    initial begin
        seed          = 32'h8c85;
        rst_n        <= 1'b0;
        cfg_wr       <= 1'b0;
        cfg_lane     <= '0;
        cfg_data     <= '0;
        start        <= '0;
        bank_wr      <= '0;
        wr_lane      <= '0;
        shacc_clr    <= '0;
        ic_clr       <= 1'b0;
        ic_recv_from <= '0;
        $readmemh("bench/mvu_cases.txt", cases);
        if ($isunknown(cases[0]) || cases[0] == '0) abort_run("Case file missing or empty");
        parse_cases();
        check_case_file();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (int l = 0; l < NMVU; l++) begin
            check_flag($sformatf("done[%0d]", l), done[l], 1'b0);
            check_flag($sformatf("irq[%0d]", l), irq[l], 1'b0);
        end
        repeat (8) begin
            @(negedge clk);
            check_flag("ic_valid", ic_valid, 1'b0);  // Nothing started yet
        end
        for (int b = 0; b < nbatch; b++) begin
            run_batch(b);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: flist.f
logic/mvu_cfg_pkg.sv
logic/mvu_data_pkg.sv
logic/mvu_job_dispatch.sv
logic/mvu_lane.sv
logic/mvu_result_mux.sv
logic/mvu_array_top.sv
bench/tb_mvu_array.sv

// File: logic/mvu_array_top.sv
`timescale 1ns/1ps
/*
 * Top of the lane array: dispatcher, four lanes and the result readout.
 * From a start to ic_valid takes the run length plus three cycles.
 */
module mvu_array_top
    import mvu_cfg_pkg::*;
    import mvu_data_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_wr,                 // Job setting write strobe
    input  mvu_idx_t        cfg_lane,
    input  job_cfg_t        cfg_data,
    input  logic [NMVU-1:0] start,                  // Per-lane start pulse
    input  bank_wr_t        bank_wr,                // Controller bank write
    input  mvu_idx_t        wr_lane,
    input  logic [NMVU-1:0] shacc_clr,              // Per-lane accumulator clear
    input  logic            ic_clr,                 // Interconnect clear
    input  mvu_idx_t        ic_recv_from,           // Interconnect source lane
    output logic [NMVU-1:0] done,
    output logic [NMVU-1:0] irq,
    output lane_result_t    ic_word,
    output logic            ic_valid
);

    job_cfg_t        lane_cfg     [NMVU];
    bank_wr_t        lane_bank_wr [NMVU];
    lane_result_t    lane_result  [NMVU];
    logic [NMVU-1:0] lane_start;

    mvu_job_dispatch u_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg_lane     (cfg_lane),
        .cfg_data     (cfg_data),
        .start_in     (start),
        .bank_wr_in   (bank_wr),
        .wr_lane      (wr_lane),
        .lane_cfg     (lane_cfg),
        .lane_start   (lane_start),
        .lane_bank_wr (lane_bank_wr)
    );

    for (genvar i = 0; i < NMVU; i++) begin : g_lane
        mvu_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .cfg       (lane_cfg[i]),
            .start     (lane_start[i]),
            .shacc_clr (shacc_clr[i]),
            .bank_wr   (lane_bank_wr[i]),
            .done      (done[i]),
            .irq       (irq[i]),
            .result    (lane_result[i])
        );
    end

    mvu_result_mux u_result_mux (
        .clk          (clk),
        .rst_n        (rst_n),
        .ic_clr       (ic_clr),
        .ic_recv_from (ic_recv_from),
        .lane_irq     (irq),
        .lane_start   (lane_start),
        .lane_result  (lane_result),
        .ic_word      (ic_word),
        .ic_valid     (ic_valid)
    );

endmodule

// File: logic/mvu_cfg_pkg.sv
/*
 * Job setting types for the matrix-vector lane array.
 * Imported by the dispatcher, the lanes and the top level.
 */
package mvu_cfg_pkg;

    // Array shape
    localparam int NMVU     = 4;            // Number of lanes
    localparam int BMVUA    = 2;            // Lane index width

    // Data bank addressing
    localparam int BDBANKA  = 6;            // Bank address width, 64 words
    localparam int BSTRIDE  = BDBANKA;      // Stride wraps with the address anyway
    localparam int BLENGTH  = 16;           // Run length, stored as count minus one

    // Quantizer
    localparam int BQMSBIDX = 5;            // Selects a bit of the 32-bit accumulator

    typedef logic [BMVUA-1:0]    mvu_idx_t;       // Lane number
    typedef logic [BDBANKA-1:0]  bank_addr_t;     // Word address in one bank
    typedef logic [BQMSBIDX-1:0] quant_msbidx_t;  // Top bit of the quantizer slice

    // Multiply mode of a job
    typedef enum logic [1:0] {
        MUL_INT8 = 2'd0,                    // Four signed 8-bit elements per word
        MUL_BIN  = 2'd1                     // 32 binary +1/-1 elements per word
    } mul_mode_e;

    /*
     * One lane's job. The weight word has the layout of a data word and
     * is decoded the same way by the lane.
     */
    typedef struct packed {
        bank_addr_t          base;          // First input address
        logic [BSTRIDE-1:0]  stride;        // Address step
        logic [BLENGTH-1:0]  length;        // Word count minus one
        mul_mode_e           mode;          // Multiply mode
        quant_msbidx_t       msbidx;        // Quantizer MSB index, 7 or more
        logic [31:0]         weight;        // Weight word held for the whole run
    } job_cfg_t;

endpackage

// File: logic/mvu_data_pkg.sv
/*
 * Data word, accumulator and result types of the lane array.
 * Compiled after the job setting package, whose bank address it reuses.
 */
package mvu_data_pkg;

    import mvu_cfg_pkg::*;

    localparam int N     = 32;              // Data word width
    localparam int NELEM = 4;               // 8-bit elements per word
    localparam int BELEM = N / NELEM;       // Element width
    localparam int BACC  = 32;              // Accumulator width
    localparam int BQOUT = 8;               // Quantized output width

    typedef logic signed [BELEM-1:0] elem8_t;   // One signed element

    // A bank word, read by mode as packed bytes or as plain bits
    typedef union packed {
        elem8_t [NELEM-1:0] e8;             // MUL_INT8 view
        logic   [N-1:0]     bits;           // MUL_BIN view, 1 means +1
    } data_word_u;

    typedef logic signed [BACC-1:0] acc_t;  // Accumulator word

    // Controller write into one data bank
    typedef struct packed {
        logic        en;                    // Write strobe
        bank_addr_t  addr;                  // Word address
        data_word_u  data;                  // Word to store
    } bank_wr_t;

    // What a lane offers to the interconnect
    typedef struct packed {
        logic [BQOUT-1:0] qout;             // Quantizer slice
        acc_t             acc;              // Raw accumulator
    } lane_result_t;

endpackage

// File: logic/mvu_job_dispatch.sv
`timescale 1ns/1ps
/*
 * Holds the job setting of every lane and steers controller bank writes.
 * Settings and bank writes land one cycle after the strobe, start is passed on.
 */
module mvu_job_dispatch
    import mvu_cfg_pkg::*;
    import mvu_data_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_wr,                 // Setting write strobe
    input  mvu_idx_t        cfg_lane,               // Lane whose setting is written
    input  job_cfg_t        cfg_data,               // New setting
    input  logic [NMVU-1:0] start_in,               // Start pulses from outside
    input  bank_wr_t        bank_wr_in,             // Controller bank write
    input  mvu_idx_t        wr_lane,                // Lane that owns the bank write
    output job_cfg_t        lane_cfg [NMVU],        // Per-lane setting
    output logic [NMVU-1:0] lane_start,             // Per-lane start
    output bank_wr_t        lane_bank_wr [NMVU]     // Per-lane bank write
);

    logic [NMVU-1:0] wr_en_q;                       // Decoded write strobes
    bank_addr_t      wr_addr_q;                     // Shared by all lanes
    data_word_u      wr_data_q;

    // Setting registers, one per lane
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NMVU; i++) begin
                lane_cfg[i] <= '0;
            end
        end else if (cfg_wr) begin
            lane_cfg[cfg_lane] <= cfg_data;
        end
    end

    // Lane decode of the bank write strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en_q <= '0;
        end else begin
            for (int i = 0; i < NMVU; i++) begin
                wr_en_q[i] <= bank_wr_in.en && (wr_lane == mvu_idx_t'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q <= bank_wr_in.addr;
        wr_data_q <= bank_wr_in.data;
    end

    always_comb begin
        for (int i = 0; i < NMVU; i++) begin
            lane_bank_wr[i] = '{en: wr_en_q[i], addr: wr_addr_q, data: wr_data_q};
        end
    end

    assign lane_start = start_in;                   // Setting is already a cycle old

    // The lane would latch the old setting otherwise
    a_cfg_before_start: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_wr |-> !start_in[cfg_lane]);

endmodule

// File: logic/mvu_lane.sv
`timescale 1ns/1ps
/*
 * One matrix-vector lane. Runs a strided read over its data bank, multiplies
 * each word with the job weight and accumulates. done and irq mark the end.
 */
module mvu_lane
    import mvu_cfg_pkg::*;
    import mvu_data_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  job_cfg_t     cfg,                       // Setting from the dispatcher
    input  logic         start,                     // Starts a job
    input  logic         shacc_clr,                 // Zeroes the accumulator
    input  bank_wr_t     bank_wr,                   // Controller write port
    output logic         done,                      // High from job end to next start
    output logic         irq,                       // One cycle at job end
    output lane_result_t result                     // Quantized and raw accumulator
);

    data_word_u         bank [2**BDBANKA];          // Data bank
    job_cfg_t           job;                        // Setting latched at start
    data_word_u         weight;
    bank_addr_t         addr;                       // Current read address
    logic [BLENGTH-1:0] remain;                     // Reads left after this one
    logic               run;                        // Address run active
    logic               rd_vld;                     // rd_word holds a run word
    logic               rd_last;                    // rd_word is the last of the run
    data_word_u         rd_word;
    acc_t               prod;                       // Product of the word in rd_word
    acc_t               acc;

    assign weight = job.weight;

    // Controller writes
    always_ff @(posedge clk) begin
        if (bank_wr.en) begin
            bank[bank_wr.addr] <= bank_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        rd_word <= bank[addr];                      // One cycle read latency
    end

    always_ff @(posedge clk) begin
        if (start) begin
            job <= cfg;
        end
    end

    // Strided address run, base first, wraps modulo bank size
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run    <= 1'b0;
            addr   <= '0;
            remain <= '0;
        end else if (start) begin
            run    <= 1'b1;
            addr   <= cfg.base;
            remain <= cfg.length;                   // Count minus one
        end else if (run) begin
            addr   <= addr + job.stride;
            remain <= remain - 1'b1;
            run    <= (remain != '0);               // Stops after the last address
        end
    end

    // Tracks the read in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld  <= 1'b0;
            rd_last <= 1'b0;
        end else begin
            rd_vld  <= run;
            rd_last <= run && (remain == '0);
        end
    end

    // Same word, two decodes
    always_comb begin
        prod = '0;
        case (job.mode)
            MUL_INT8: begin
                for (int i = 0; i < NELEM; i++) begin
                    prod = prod + acc_t'($signed(rd_word.e8[i])) * acc_t'($signed(weight.e8[i]));
                end
            end
            // Matches count +1, mismatches count -1
            MUL_BIN: prod = acc_t'(2 * $countones(~(rd_word.bits ^ weight.bits))) - acc_t'(N);
            default: prod = '0;
        endcase
    end

    // A clear on the same edge as a product drops that product
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (start || shacc_clr) begin
            acc <= '0;
        end else if (rd_vld) begin
            acc <= acc + prod;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
            irq  <= 1'b0;
        end else begin
            irq <= rd_last;                         // Last product lands now
            if (start) begin
                done <= 1'b0;
            end else if (rd_last) begin
                done <= 1'b1;
            end
        end
    end

    // Quantizer, a plain slice
    assign result.acc  = acc;
    assign result.qout = acc[job.msbidx -: BQOUT];

    // Run and read pipeline must drain before the next job
    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !(run || rd_vld));

    // Slice would leave the accumulator otherwise
    a_msbidx_range: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> (cfg.msbidx >= quant_msbidx_t'(BQOUT - 1)));

endmodule

// File: logic/mvu_result_mux.sv
`timescale 1ns/1ps
/*
 * Interconnect readout. Captures the result of the lane picked by
 * ic_recv_from when that lane raises irq and holds it with ic_valid.
 */
module mvu_result_mux
    import mvu_cfg_pkg::*;
    import mvu_data_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ic_clr,                 // Drops ic_valid
    input  mvu_idx_t        ic_recv_from,           // Lane to listen to
    input  logic [NMVU-1:0] lane_irq,               // Job end pulses
    input  logic [NMVU-1:0] lane_start,             // New job makes the held result stale
    input  lane_result_t    lane_result [NMVU],
    output lane_result_t    ic_word,                // Held result
    output logic            ic_valid
);

    logic         sel_irq;
    logic         sel_start;
    lane_result_t sel_result;

    // Selected lane only
    assign sel_irq    = lane_irq[ic_recv_from];
    assign sel_start  = lane_start[ic_recv_from];
    assign sel_result = lane_result[ic_recv_from];

    // Result is final in the irq cycle
    always_ff @(posedge clk) begin
        if (sel_irq) begin
            ic_word <= sel_result;
        end
    end

    // Clear beats capture
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ic_valid <= 1'b0;
        end else if (ic_clr || sel_start) begin
            ic_valid <= 1'b0;
        end else if (sel_irq) begin
            ic_valid <= 1'b1;
        end
    end

    // Lane select names a real lane
    a_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(ic_recv_from));

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the lane array testbench with Verilator, runs it and looks for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_mvu_array -Mdir obj_dir \
    -f flist.f &&
./obj_dir/Vtb_mvu_array | tee /dev/stderr | grep -qF "=== PASS ===" &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }
